//--- source/matmul_defs.svh
`ifndef MATMUL_DEFS_SVH
`define MATMUL_DEFS_SVH

// Operand element width and matrix size
`define DWIDTH             8
`define MAT_SIZE           4

// Operand RAMs are 64 words deep
`define AWIDTH             6
`define STRIDE_WIDTH       4
`define MEM_ACCESS_LATENCY 1

// One mask bit per row, column or inner index
`define MASK_WIDTH         4

// Four 8x8 products need 18 bits and two more are spare
`define ACC_WIDTH          20

// Issue, read latency, skew, grid propagation and some margin
`define COMPUTE_CYCLES     16

`endif

//--- source/matmul_pkg.sv
`include "matmul_defs.svh"

package matmul_pkg;

    ////////////////////////////////////////
    // Operand RAM word
    ////////////////////////////////////////

    // The RAMs and the load port see the raw view
    // Data setup splits the same word into its lanes
    typedef union packed {
        logic [`MAT_SIZE*`DWIDTH-1:0]      raw;
        logic [`MAT_SIZE-1:0][`DWIDTH-1:0] lane;
    } operand_word_u;

    ////////////////////////////////////////
    // Result
    ////////////////////////////////////////

    // One row of C with element c in lane c
    typedef logic [`MAT_SIZE-1:0][`ACC_WIDTH-1:0] result_row_t;

endpackage

//--- source/systolic_feed_if.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

interface systolic_feed_if;

    // Lane i of each operand is already delayed by i cycles
    logic [`MAT_SIZE-1:0][`DWIDTH-1:0] a_lane;
    logic [`MAT_SIZE-1:0][`DWIDTH-1:0] b_lane;

    // Zeroes the accumulators and operand registers of the grid
    logic                              clear;

    // Grid advances only while this is high
    logic                              feed_en;

    modport setup (
        output a_lane,
        output b_lane,
        output clear,
        output feed_en
    );

    modport grid (
        input  a_lane,
        input  b_lane,
        input  clear,
        input  feed_en
    );

endinterface

//--- source/operand_ram.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module operand_ram (
    input  logic                      clk,
    input  logic                      wr_en,
    input  logic [`AWIDTH-1:0]        wr_addr,
    input  matmul_pkg::operand_word_u wr_data,
    input  logic                      rd_en,
    input  logic [`AWIDTH-1:0]        rd_addr,
    output matmul_pkg::operand_word_u rd_data
);

    import matmul_pkg::*;

    operand_word_u mem [2**`AWIDTH];

    // Load port writes one word per cycle
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read where data follows the address by one cycle
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- source/systolic_data_setup.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module systolic_data_setup (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [7:0]                clk_cnt,
    input  logic                      busy,
    input  logic                      clear,
    input  logic [`AWIDTH-1:0]        addr_a,
    input  logic [`AWIDTH-1:0]        addr_b,
    input  logic [`STRIDE_WIDTH-1:0]  stride_a,
    input  logic [`STRIDE_WIDTH-1:0]  stride_b,
    input  logic [`MASK_WIDTH-1:0]    mask_a_rows,
    input  logic [`MASK_WIDTH-1:0]    mask_k,
    input  logic [`MASK_WIDTH-1:0]    mask_b_cols,
    output logic                      a_rd_en,
    output logic                      b_rd_en,
    output logic [`AWIDTH-1:0]        a_rd_addr,
    output logic [`AWIDTH-1:0]        b_rd_addr,
    input  matmul_pkg::operand_word_u a_rd_data,
    input  matmul_pkg::operand_word_u b_rd_data,
    systolic_feed_if.setup            feed
);

    import matmul_pkg::*;

    // Index 0 carries operand A, index 1 operand B
    logic [`AWIDTH-1:0]                base       [2];
    logic [`STRIDE_WIDTH-1:0]          stride     [2];
    logic [`MASK_WIDTH-1:0]            lane_mask  [2];
    operand_word_u                     rd_word    [2];
    logic [`AWIDTH-1:0]                next_addr  [2];
    logic [`AWIDTH-1:0]                rd_addr    [2];
    logic [2:0]                        rd_cnt     [2];
    logic [1:0]                        word_idx   [2];
    logic                              word_valid [2];
    logic [`MAT_SIZE-1:0][`DWIDTH-1:0] lane       [2];
    logic [`DWIDTH-1:0]                skew1      [2];
    logic [1:0][`DWIDTH-1:0]           skew2      [2];
    logic [2:0][`DWIDTH-1:0]           skew3      [2];
    logic                              issue;

    assign base      = '{addr_a, addr_b};
    assign stride    = '{stride_a, stride_b};
    assign lane_mask = '{mask_a_rows, mask_b_cols};
    assign rd_word   = '{a_rd_data, b_rd_data};

    ////////////////////////////////////////
    // Address sweep
    ////////////////////////////////////////

    // One word per operand on each of the first MAT_SIZE counts
    assign issue     = busy && (clk_cnt < `MAT_SIZE);
    assign a_rd_en   = issue;
    assign b_rd_en   = issue;
    assign a_rd_addr = rd_addr[0];
    assign b_rd_addr = rd_addr[1];

    for (genvar op = 0; op < 2; op++)
    begin : g_op
        // Word 0 reads the base straight away, later words the running address
        assign rd_addr[op] = (clk_cnt == 8'd0) ? base[op] : next_addr[op];

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                next_addr[op] <= '0;
            end
            else if (issue)
            begin
                next_addr[op] <= rd_addr[op] + `AWIDTH'(stride[op]);
            end
        end

        ////////////////////////////////////////
        // Read valid and mask qualification
        ////////////////////////////////////////

        // Counts issued words, so word k comes back while the count reads k+1
        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                rd_cnt[op] <= '0;
            end
            else if (issue)
            begin
                rd_cnt[op] <= rd_cnt[op] + 3'd1;
            end
            else
            begin
                rd_cnt[op] <= '0;
            end
        end

        assign word_idx[op]   = 2'(rd_cnt[op] - 3'd1);
        assign word_valid[op] = (rd_cnt[op] >= `MEM_ACCESS_LATENCY) && mask_k[word_idx[op]];

        always_comb
        begin
            for (int i = 0; i < `MAT_SIZE; i++)
            begin
                lane[op][i] = rd_word[op].lane[i] & {`DWIDTH{word_valid[op] & lane_mask[op][i]}};
            end
        end

        ////////////////////////////////////////
        // Lane skew
        ////////////////////////////////////////

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                skew1[op] <= '0;
                skew2[op] <= '0;
                skew3[op] <= '0;
            end
            else if (clear)
            begin
                skew1[op] <= '0;
                skew2[op] <= '0;
                skew3[op] <= '0;
            end
            else
            begin
                skew1[op] <= lane[op][1];
                skew2[op] <= {skew2[op][0], lane[op][2]};
                skew3[op] <= {skew3[op][1:0], lane[op][3]};
            end
        end
    end

    assign feed.a_lane  = {skew3[0][2], skew2[0][1], skew1[0], lane[0][0]};
    assign feed.b_lane  = {skew3[1][2], skew2[1][1], skew1[1], lane[1][0]};
    assign feed.clear   = clear;
    assign feed.feed_en = busy && !clear;

    // Consecutive words of one sweep sit exactly one stride apart
    a_stride_step: assert property (@(posedge clk) disable iff (!rst_n)
        a_rd_en && $past(a_rd_en) |->
            a_rd_addr == `AWIDTH'($past(a_rd_addr) + $past(stride_a)));

    b_stride_step: assert property (@(posedge clk) disable iff (!rst_n)
        b_rd_en && $past(b_rd_en) |->
            b_rd_addr == `AWIDTH'($past(b_rd_addr) + $past(stride_b)));

    // No RAM reads while the controller is idle or draining
    rd_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
        !busy |-> !a_rd_en && !b_rd_en);

endmodule

//--- source/systolic_mac_grid.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module systolic_mac_grid (
    input  logic                    clk,
    input  logic                    rst_n,
    systolic_feed_if.grid           feed,
    output matmul_pkg::result_row_t acc [`MAT_SIZE]
);

    // Operand registers double as the links to the next cell
    logic [`DWIDTH-1:0]   a_q  [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0]   b_q  [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0]   a_in [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0]   b_in [`MAT_SIZE][`MAT_SIZE];
    logic [`ACC_WIDTH-1:0] sum [`MAT_SIZE][`MAT_SIZE];

    for (genvar r = 0; r < `MAT_SIZE; r++)
    begin : g_row
        for (genvar c = 0; c < `MAT_SIZE; c++)
        begin : g_col
            // A enters on the left edge and moves right
            if (c == 0)
            begin : g_a_edge
                assign a_in[r][c] = feed.a_lane[r];
            end
            else
            begin : g_a_pass
                assign a_in[r][c] = a_q[r][c-1];
            end

            // B enters on the top edge and moves down
            if (r == 0)
            begin : g_b_edge
                assign b_in[r][c] = feed.b_lane[c];
            end
            else
            begin : g_b_pass
                assign b_in[r][c] = b_q[r-1][c];
            end

            always_ff @(posedge clk or negedge rst_n)
            begin
                if (!rst_n)
                begin
                    a_q[r][c] <= '0;
                    b_q[r][c] <= '0;
                    sum[r][c] <= '0;
                end
                else if (feed.clear)
                begin
                    a_q[r][c] <= '0;
                    b_q[r][c] <= '0;
                    sum[r][c] <= '0;
                end
                else if (feed.feed_en)
                begin
                    a_q[r][c] <= a_in[r][c];
                    b_q[r][c] <= b_in[r][c];
                    sum[r][c] <= sum[r][c] + a_in[r][c] * b_in[r][c];
                end
            end
        end

        assign acc[r] = {sum[r][3], sum[r][2], sum[r][1], sum[r][0]};

        // A new job always starts from an empty row
        acc_cleared: assert property (@(posedge clk) disable iff (!rst_n)
            feed.clear |=> acc[r] == '0);
    end

endmodule

//--- source/matmul_ctrl.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matmul_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_valid,
    output logic                    start_ready,
    output logic                    busy,
    output logic                    clear,
    output logic [7:0]              clk_cnt,
    input  matmul_pkg::result_row_t acc [`MAT_SIZE],
    output logic                    result_valid,
    input  logic                    result_ready,
    output matmul_pkg::result_row_t result_row,
    output logic [1:0]              result_index
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPUTE,
        ST_DRAIN
    } state_t;

    state_t     state;
    logic [1:0] row_idx;

    assign start_ready  = (state == ST_IDLE);
    assign busy         = (state == ST_COMPUTE);
    assign result_valid = (state == ST_DRAIN);
    assign result_index = row_idx;
    assign result_row   = acc[row_idx];

    ////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state   <= ST_IDLE;
            clk_cnt <= '0;
            clear   <= 1'b0;
            row_idx <= '0;
        end
        else
        begin
            clear <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (start_valid)
                    begin
                        state   <= ST_COMPUTE;
                        clk_cnt <= '0;
                        clear   <= 1'b1;
                    end
                end
                ST_COMPUTE:
                begin
                    clk_cnt <= clk_cnt + 8'd1;
                    if (clk_cnt == 8'(`COMPUTE_CYCLES - 1))
                    begin
                        state   <= ST_DRAIN;
                        row_idx <= '0;
                    end
                end
                ST_DRAIN:
                begin
                    // One row per accepted beat and back to idle after the last
                    if (result_ready)
                    begin
                        row_idx <= row_idx + 2'd1;
                        if (row_idx == 2'(`MAT_SIZE - 1))
                        begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // A stalled beat keeps its row, which needs the grid to stay frozen
    result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=>
            result_valid && $stable(result_row) && $stable(result_index));

endmodule

//--- source/matmul_top.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matmul_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         wr_en,
    input  logic                         wr_sel,
    input  logic [`AWIDTH-1:0]           wr_addr,
    input  logic [`MAT_SIZE*`DWIDTH-1:0] wr_data,
    input  logic                         start_valid,
    output logic                         start_ready,
    input  logic [`AWIDTH-1:0]           addr_a,
    input  logic [`AWIDTH-1:0]           addr_b,
    input  logic [`STRIDE_WIDTH-1:0]     stride_a,
    input  logic [`STRIDE_WIDTH-1:0]     stride_b,
    input  logic [`MASK_WIDTH-1:0]       mask_a_rows,
    input  logic [`MASK_WIDTH-1:0]       mask_k,
    input  logic [`MASK_WIDTH-1:0]       mask_b_cols,
    output logic                         result_valid,
    input  logic                         result_ready,
    output matmul_pkg::result_row_t      result_row,
    output logic [1:0]                   result_index
);

    import matmul_pkg::*;

    operand_word_u             a_rd_data;
    operand_word_u             b_rd_data;
    result_row_t               acc [`MAT_SIZE];
    logic                      busy;
    logic                      clear;
    logic [7:0]                clk_cnt;
    logic                      a_rd_en;
    logic                      b_rd_en;
    logic [`AWIDTH-1:0]        a_rd_addr;
    logic [`AWIDTH-1:0]        b_rd_addr;
    logic [`AWIDTH-1:0]        job_addr_a;
    logic [`AWIDTH-1:0]        job_addr_b;
    logic [`STRIDE_WIDTH-1:0]  job_stride_a;
    logic [`STRIDE_WIDTH-1:0]  job_stride_b;
    logic [`MASK_WIDTH-1:0]    job_mask_a_rows;
    logic [`MASK_WIDTH-1:0]    job_mask_k;
    logic [`MASK_WIDTH-1:0]    job_mask_b_cols;

    systolic_feed_if feed ();

    // Job settings are captured once, when the start handshake completes
    always_ff @(posedge clk)
    begin
        if (start_valid && start_ready)
        begin
            job_addr_a      <= addr_a;
            job_addr_b      <= addr_b;
            job_stride_a    <= stride_a;
            job_stride_b    <= stride_b;
            job_mask_a_rows <= mask_a_rows;
            job_mask_k      <= mask_k;
            job_mask_b_cols <= mask_b_cols;
        end
    end

    ////////////////////////////////////////
    // Operand RAMs
    ////////////////////////////////////////

    operand_ram u_ram_a (
        .clk     (clk),
        .wr_en   (wr_en && !wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (a_rd_en),
        .rd_addr (a_rd_addr),
        .rd_data (a_rd_data)
    );

    operand_ram u_ram_b (
        .clk     (clk),
        .wr_en   (wr_en && wr_sel),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (b_rd_en),
        .rd_addr (b_rd_addr),
        .rd_data (b_rd_data)
    );

    ////////////////////////////////////////
    // Datapath and control
    ////////////////////////////////////////

    systolic_data_setup u_setup (
        .clk         (clk),
        .rst_n       (rst_n),
        .clk_cnt     (clk_cnt),
        .busy        (busy),
        .clear       (clear),
        .addr_a      (job_addr_a),
        .addr_b      (job_addr_b),
        .stride_a    (job_stride_a),
        .stride_b    (job_stride_b),
        .mask_a_rows (job_mask_a_rows),
        .mask_k      (job_mask_k),
        .mask_b_cols (job_mask_b_cols),
        .a_rd_en     (a_rd_en),
        .b_rd_en     (b_rd_en),
        .a_rd_addr   (a_rd_addr),
        .b_rd_addr   (b_rd_addr),
        .a_rd_data   (a_rd_data),
        .b_rd_data   (b_rd_data),
        .feed        (feed.setup)
    );

    systolic_mac_grid u_grid (
        .clk   (clk),
        .rst_n (rst_n),
        .feed  (feed.grid),
        .acc   (acc)
    );

    matmul_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_valid  (start_valid),
        .start_ready  (start_ready),
        .busy         (busy),
        .clear        (clear),
        .clk_cnt      (clk_cnt),
        .acc          (acc),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .result_row   (result_row),
        .result_index (result_index)
    );

endmodule

//--- verif/matmul_tb.sv
`timescale 1ns/10ps
`include "matmul_defs.svh"

module matmul_tb;

    import matmul_pkg::*;

    localparam int START_TIMEOUT = 100;
    localparam int JOB_TIMEOUT   = 400;

    logic                         clk;
    logic                         rst_n;
    logic                         wr_en;
    logic                         wr_sel;
    logic [`AWIDTH-1:0]           wr_addr;
    logic [`MAT_SIZE*`DWIDTH-1:0] wr_data;
    logic                         start_valid;
    logic                         start_ready;
    logic [`AWIDTH-1:0]           addr_a;
    logic [`AWIDTH-1:0]           addr_b;
    logic [`STRIDE_WIDTH-1:0]     stride_a;
    logic [`STRIDE_WIDTH-1:0]     stride_b;
    logic [`MASK_WIDTH-1:0]       mask_a_rows;
    logic [`MASK_WIDTH-1:0]       mask_k;
    logic [`MASK_WIDTH-1:0]       mask_b_cols;
    logic                         result_valid;
    logic                         result_ready;
    result_row_t                  result_row;
    logic [1:0]                   result_index;

    logic [`DWIDTH-1:0] a_mat [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0] b_mat [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0] a_save [`MAT_SIZE][`MAT_SIZE];
    logic [`DWIDTH-1:0] b_save [`MAT_SIZE][`MAT_SIZE];
    result_row_t        expected [`MAT_SIZE];
    result_row_t        expected_row;
    logic [31:0]        lcg_state = 32'h7359;
    string              test_name = "reset";
    int                 error_count = 0;
    int                 test_errors;
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 beat_count;
    logic               in_job;

    matmul_top uut (.*);

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #10 clk = ~clk;
        end
    end

    assign expected_row = expected[result_index];

    // Beats since the last accepted job, and whether a job is in flight
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat_count <= 0;
            in_job     <= 1'b0;
        end
        else if (start_valid && start_ready)
        begin
            beat_count <= 0;
            in_job     <= 1'b1;
        end
        else if (result_valid && result_ready)
        begin
            beat_count <= beat_count + 1;
            if (result_index == 2'(`MAT_SIZE - 1))
            begin
                in_job <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    row_value: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result_ready |-> result_row == expected_row)
    else
    begin
        $display("ERROR %s row %0d expected %h actual %h", test_name,
                 $sampled(result_index), $sampled(expected_row), $sampled(result_row));
        error_count++;
    end

    row_order: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && result_ready |-> result_index == 2'(beat_count))
    else
    begin
        $display("ERROR %s row order expected %0d actual %0d", test_name,
                 2'($sampled(beat_count)), $sampled(result_index));
        error_count++;
    end

    row_hold: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=>
            result_valid && $stable(result_row) && $stable(result_index))
    else
    begin
        $display("%s: a stalled result beat changed before it was accepted", test_name);
        error_count++;
    end

    busy_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        in_job |-> !start_ready)
    else
    begin
        $display("%s: start_ready went high while a job was running", test_name);
        error_count++;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void fill_random();
        logic [31:0] rnd;
        for (int i = 0; i < `MAT_SIZE; i++)
        begin
            for (int j = 0; j < `MAT_SIZE; j++)
            begin
                rnd = next_rand();
                a_mat[i][j] = rnd[23:16];
                rnd = next_rand();
                b_mat[i][j] = rnd[23:16];
            end
        end
    endfunction

    // C[r][c] keeps a term only where its row, inner index and column are all enabled
    function automatic void compute_expected(input logic [`MASK_WIDTH-1:0] m_rows,
                                             input logic [`MASK_WIDTH-1:0] m_k,
                                             input logic [`MASK_WIDTH-1:0] m_cols);
        int sum;
        for (int r = 0; r < `MAT_SIZE; r++)
        begin
            for (int c = 0; c < `MAT_SIZE; c++)
            begin
                sum = 0;
                for (int k = 0; k < `MAT_SIZE; k++)
                begin
                    if (m_rows[r] && m_k[k] && m_cols[c])
                    begin
                        sum += int'(a_mat[r][k]) * int'(b_mat[k][c]);
                    end
                end
                expected[r][c] = `ACC_WIDTH'(sum);
            end
        end
    endfunction

    task automatic abort_run(input string reason);
        $display("%s: %s", test_name, reason);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic write_word(input logic sel, input logic [`AWIDTH-1:0] addr,
                              input logic [`MAT_SIZE*`DWIDTH-1:0] data);
        wr_en   = 1'b1;
        wr_sel  = sel;
        wr_addr = addr;
        wr_data = data;
        @(negedge clk);
        wr_en   = 1'b0;
    endtask

    // A goes in column by column, B row by row, element i in lane i
    task automatic load_matrices(input int base_a, input int step_a,
                                 input int base_b, input int step_b);
        logic [`MAT_SIZE*`DWIDTH-1:0] word;
        for (int k = 0; k < `MAT_SIZE; k++)
        begin
            for (int i = 0; i < `MAT_SIZE; i++)
            begin
                word[i*`DWIDTH +: `DWIDTH] = a_mat[i][k];
            end
            write_word(1'b0, `AWIDTH'(base_a + k * step_a), word);
            for (int i = 0; i < `MAT_SIZE; i++)
            begin
                word[i*`DWIDTH +: `DWIDTH] = b_mat[k][i];
            end
            write_word(1'b1, `AWIDTH'(base_b + k * step_b), word);
        end
    endtask

    task automatic run_job(input int base_a, input int step_a, input int base_b,
                           input int step_b, input logic [`MASK_WIDTH-1:0] m_rows,
                           input logic [`MASK_WIDTH-1:0] m_k,
                           input logic [`MASK_WIDTH-1:0] m_cols, input logic stall);
        int          cycles;
        logic [31:0] rnd;
        compute_expected(m_rows, m_k, m_cols);
        cycles = 0;
        while (!start_ready && cycles < START_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!start_ready)
        begin
            abort_run("start_ready did not come back high");
        end
        addr_a      = `AWIDTH'(base_a);
        addr_b      = `AWIDTH'(base_b);
        stride_a    = `STRIDE_WIDTH'(step_a);
        stride_b    = `STRIDE_WIDTH'(step_b);
        mask_a_rows = m_rows;
        mask_k      = m_k;
        mask_b_cols = m_cols;
        start_valid = 1'b1;
        @(negedge clk);
        start_valid = 1'b0;
        cycles = 0;
        while (beat_count < `MAT_SIZE && cycles < JOB_TIMEOUT)
        begin
            rnd = next_rand();
            result_ready = stall ? rnd[20] : 1'b1;
            @(negedge clk);
            cycles++;
        end
        result_ready = 1'b0;
        if (beat_count < `MAT_SIZE)
        begin
            abort_run("not all result rows arrived in time");
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = error_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (error_count == test_errors)
        begin
            $display("test %s: ok", test_name);
        end
        else
        begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - test_errors);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        rst_n        = 1'b0;
        wr_en        = 1'b0;
        wr_sel       = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        start_valid  = 1'b0;
        addr_a       = '0;
        addr_b       = '0;
        stride_a     = '0;
        stride_b     = '0;
        mask_a_rows  = '0;
        mask_k       = '0;
        mask_b_cols  = '0;
        result_ready = 1'b0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        // Identity A hands B back unchanged
        begin_test("identity");
        fill_random();
        for (int i = 0; i < `MAT_SIZE; i++)
        begin
            for (int j = 0; j < `MAT_SIZE; j++)
            begin
                a_mat[i][j] = (i == j) ? 8'd1 : 8'd0;
            end
        end
        load_matrices(0, 1, 0, 1);
        run_job(0, 1, 0, 1, 4'hf, 4'hf, 4'hf, 1'b0);
        end_test();

        for (int j = 0; j < 3; j++)
        begin
            begin_test($sformatf("random_%0d", j));
            fill_random();
            load_matrices(0, 1, 0, 1);
            run_job(0, 1, 0, 1, 4'hf, 4'hf, 4'hf, 1'b0);
            end_test();
        end

        // One mask kind at a time, then all three together
        fill_random();
        load_matrices(0, 1, 0, 1);
        begin_test("mask_rows");
        run_job(0, 1, 0, 1, 4'b0101, 4'hf, 4'hf, 1'b0);
        end_test();
        begin_test("mask_k");
        run_job(0, 1, 0, 1, 4'hf, 4'b1011, 4'hf, 1'b0);
        end_test();
        begin_test("mask_cols");
        run_job(0, 1, 0, 1, 4'hf, 4'hf, 4'b0110, 1'b0);
        end_test();
        begin_test("mask_all");
        run_job(0, 1, 0, 1, 4'b1101, 4'b0110, 4'b1010, 1'b0);
        end_test();

        // Stale words from earlier tests still sit at the low addresses
        begin_test("strided");
        fill_random();
        load_matrices(5, 3, 33, 3);
        run_job(5, 3, 33, 3, 4'hf, 4'hf, 4'hf, 1'b0);
        end_test();

        begin_test("stall");
        fill_random();
        load_matrices(0, 1, 0, 1);
        run_job(0, 1, 0, 1, 4'hf, 4'hf, 4'hf, 1'b1);
        end_test();

        // Both jobs are loaded first so the second starts right after the first
        begin_test("back_to_back");
        fill_random();
        load_matrices(40, 1, 40, 1);
        a_save = a_mat;
        b_save = b_mat;
        fill_random();
        load_matrices(0, 1, 0, 1);
        run_job(0, 1, 0, 1, 4'hf, 4'hf, 4'hf, 1'b0);
        a_mat = a_save;
        b_mat = b_save;
        run_job(40, 1, 40, 1, 4'hf, 4'hf, 4'hf, 1'b0);
        end_test();

        $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- matmul.f
+incdir+source
source/matmul_pkg.sv
source/systolic_feed_if.sv
source/operand_ram.sv
source/systolic_data_setup.sv
source/systolic_mac_grid.sv
source/matmul_ctrl.sv
source/matmul_top.sv
verif/matmul_tb.sv

//--- Bender.yml
package:
  name: matmul

sources:
  - include_dirs:
      - source
    files:
      - source/matmul_pkg.sv
      - source/systolic_feed_if.sv
      - source/operand_ram.sv
      - source/systolic_data_setup.sv
      - source/systolic_mac_grid.sv
      - source/matmul_ctrl.sv
      - source/matmul_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/matmul_tb.sv
